// File: hdl/fsab_pkg.sv
package fsab_pkg;

	// request opcode as carried in the header beat.
	typedef enum logic {
		fsab_read  = 1'b0,
		fsab_write = 1'b1
	} fsab_mode_e;

	// field widths of the bus.
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int mask_w = 4;
	localparam int len_w  = 4;
	localparam int did_w  = 4;

	// a write never carries more than this many data beats.
	localparam int len_max = 8;

	// each client owns this many credits after reset.
	// the request FIFO holds one header per credit.
	localparam int initial_credits = 4;

	// the data FIFO must absorb a full-length write for every credit.
	localparam int dfif_depth = initial_credits * len_max;

	// the credit counters wrap at twice the credit count, so a lag of
	// initial_credits pulses is still seen as a difference.
	localparam int credit_w = $clog2(initial_credits) + 1;

	localparam int n_clients = 2;
	localparam int client_w  = $clog2(n_clients);

	// header as stored in the request FIFO.
	typedef struct packed {
		fsab_mode_e         mode;
		logic [did_w-1:0]   did;
		logic [did_w-1:0]   subdid;
		logic [addr_w-1:0]  addr;
		logic [len_w-1:0]   len;
	} fsab_req_t;

	// one data beat as stored in the data FIFO.
	typedef struct packed {
		logic [data_w-1:0]  data;
		logic [mask_w-1:0]  mask;
	} fsab_data_t;

	// a beat with its header alongside, as seen on a FIFO output or the bus.
	typedef struct packed {
		logic               valid;
		fsab_req_t          req;
		fsab_data_t         dat;
	} fsab_beat_t;

endpackage

// File: hdl/async_fifo.sv
`timescale 1ns/1ps

module async_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic             iclk,
	input  logic             iclk_rst_b,
	input  logic             oclk,
	input  logic             oclk_rst_b,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_dat,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_dat,
	output logic             full,
	output logic             empty
);

	// DEPTH must be a power of two of at least 4.
	// pointers carry one extra bit to tell full from empty.
	logic [WIDTH-1:0]       mem [DEPTH];

	logic [$clog2(DEPTH):0] wbin;
	logic [$clog2(DEPTH):0] wbin_next;
	logic [$clog2(DEPTH):0] wgray;
	logic [$clog2(DEPTH):0] rgray_s1;
	logic [$clog2(DEPTH):0] rgray_s2;

	logic [$clog2(DEPTH):0] rbin;
	logic [$clog2(DEPTH):0] rbin_next;
	logic [$clog2(DEPTH):0] rgray;
	logic [$clog2(DEPTH):0] wgray_s1;
	logic [$clog2(DEPTH):0] wgray_s2;

	logic                   wr_ok;
	logic                   rd_ok;

	// a write while full or a read while empty is dropped here.
	assign wr_ok     = wr_en && !full;
	assign rd_ok     = rd_en && !empty;
	assign wbin_next = wbin + {{$clog2(DEPTH){1'b0}}, wr_ok};
	assign rbin_next = rbin + {{$clog2(DEPTH){1'b0}}, rd_ok};

	// full when the write pointer is one lap ahead of the read pointer.
	// in Gray code that is the top two bits inverted and the rest equal.
	assign full  = (wgray ^ rgray_s2) == {2'b11, {($clog2(DEPTH) - 1){1'b0}}};
	assign empty = rgray == wgray_s2;

	always_ff @(posedge iclk) begin
		if (wr_ok) begin
			mem[wbin[$clog2(DEPTH)-1:0]] <= wr_dat;
		end
	end

	// the Gray pointer is a flop so that the other domain never samples a glitch.
	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			wbin     <= '0;
			wgray    <= '0;
			rgray_s1 <= '0;
			rgray_s2 <= '0;
		end else begin
			wbin     <= wbin_next;
			wgray    <= wbin_next ^ (wbin_next >> 1);
			rgray_s1 <= rgray;
			rgray_s2 <= rgray_s1;
		end
	end

	// read data holds until the next accepted read.
	always_ff @(posedge oclk) begin
		if (rd_ok) begin
			rd_dat <= mem[rbin[$clog2(DEPTH)-1:0]];
		end
	end

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			rbin     <= '0;
			rgray    <= '0;
			wgray_s1 <= '0;
			wgray_s2 <= '0;
		end else begin
			rbin     <= rbin_next;
			rgray    <= rbin_next ^ (rbin_next >> 1);
			wgray_s1 <= wgray;
			wgray_s2 <= wgray_s1;
		end
	end

endmodule

// File: hdl/credit_return_sync.sv
`timescale 1ns/1ps

module credit_return_sync (
	input  logic oclk,
	input  logic oclk_rst_b,
	input  logic iclk,
	input  logic iclk_rst_b,
	input  logic credit_oclk,
	output logic credit
);

	logic [fsab_pkg::credit_w-1:0] cnt_oclk;
	logic [fsab_pkg::credit_w-1:0] cnt_oclk_next;
	logic [fsab_pkg::credit_w-1:0] gray_oclk;
	logic [fsab_pkg::credit_w-1:0] gray_s1;
	logic [fsab_pkg::credit_w-1:0] gray_s2;
	logic [fsab_pkg::credit_w-1:0] cnt_iclk;
	logic [fsab_pkg::credit_w-1:0] gray_iclk;

	assign cnt_oclk_next = credit_oclk ? cnt_oclk + 1'b1 : cnt_oclk;

	// the Gray value is registered in oclk before it crosses.
	// a combinational Gray encoder could glitch through several codes.
	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			cnt_oclk  <= '0;
			gray_oclk <= '0;
		end else begin
			cnt_oclk  <= cnt_oclk_next;
			gray_oclk <= cnt_oclk_next ^ (cnt_oclk_next >> 1);
		end
	end

	// each mismatch is one credit still owed to the client.
	// iclk is faster than oclk, so the counter catches up one step at a time.
	assign gray_iclk = cnt_iclk ^ (cnt_iclk >> 1);
	assign credit    = gray_s2 != gray_iclk;

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			gray_s1  <= '0;
			gray_s2  <= '0;
			cnt_iclk <= '0;
		end else begin
			gray_s1 <= gray_oclk;
			gray_s2 <= gray_s1;
			if (credit) begin
				cnt_iclk <= cnt_iclk + 1'b1;
			end
		end
	end

endmodule

// File: hdl/fsab_arbiter_fifo.sv
`timescale 1ns/1ps

module fsab_arbiter_fifo (
	input  logic                 iclk,
	input  logic                 iclk_rst_b,
	input  logic                 oclk,
	input  logic                 oclk_rst_b,
	input  logic                 inp_valid,
	input  fsab_pkg::fsab_req_t  inp_req,
	input  fsab_pkg::fsab_data_t inp_dat,
	output logic                 inp_credit,
	input  logic                 start_trans,
	output logic                 empty_b,
	output logic                 active,
	output fsab_pkg::fsab_beat_t fifo_beat
);

	// request FIFO, one header per started request.
	logic                        rfif_wr;
	logic                        rfif_full;
	logic                        rfif_rd;
	logic                        rfif_empty;
	fsab_pkg::fsab_req_t         rfif_rdat;

	// data FIFO, one entry per input beat.
	logic                        dfif_wr;
	logic                        dfif_full;
	logic                        dfif_rd;
	logic                        dfif_empty;
	fsab_pkg::fsab_data_t        dfif_rdat;

	logic [fsab_pkg::len_w-1:0]  inp_len_rem;
	logic                        inp_hdr;

	logic                        rfif_rd_1a;
	logic                        dfif_rd_1a;
	logic                        active_0a;
	logic                        active_1a;
	logic [fsab_pkg::len_w-1:0]  len_rem_0a;
	logic                        credit_oclk;

	async_fifo #(
		.DEPTH (fsab_pkg::initial_credits),
		.WIDTH ($bits(fsab_pkg::fsab_req_t))
	) u_rfif (
		.iclk       (iclk),
		.iclk_rst_b (iclk_rst_b),
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.wr_en      (rfif_wr),
		.wr_dat     (inp_req),
		.rd_en      (rfif_rd),
		.rd_dat     (rfif_rdat),
		.full       (rfif_full),
		.empty      (rfif_empty)
	);

	async_fifo #(
		.DEPTH (fsab_pkg::dfif_depth),
		.WIDTH ($bits(fsab_pkg::fsab_data_t))
	) u_dfif (
		.iclk       (iclk),
		.iclk_rst_b (iclk_rst_b),
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.wr_en      (dfif_wr),
		.wr_dat     (inp_dat),
		.rd_en      (dfif_rd),
		.rd_dat     (dfif_rdat),
		.full       (dfif_full),
		.empty      (dfif_empty)
	);

	credit_return_sync u_credit (
		.oclk        (oclk),
		.oclk_rst_b  (oclk_rst_b),
		.iclk        (iclk),
		.iclk_rst_b  (iclk_rst_b),
		.credit_oclk (credit_oclk),
		.credit      (inp_credit)
	);

	// a beat is a header when no write is in progress.
	// a count of 1 means the previous beat was the last one of a write.
	assign inp_hdr = (inp_len_rem == '0) || (inp_len_rem == 'd1);
	assign rfif_wr = inp_valid && inp_hdr;

	// every beat goes to the data FIFO, reads included.
	// the readout side relies on this and always pops one entry per header.
	assign dfif_wr = inp_valid;

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			inp_len_rem <= '0;
		end else if (inp_valid && inp_hdr && inp_req.mode == fsab_pkg::fsab_write) begin
			inp_len_rem <= inp_req.len;
		end else if (inp_valid && inp_len_rem != '0) begin
			inp_len_rem <= inp_len_rem - 1'b1;
		end
	end

	// empty_b may rise before all data of a write has crossed.
	// the readout then stalls on an empty data FIFO and holds active.
	assign empty_b = !rfif_empty;

	// header and first data beat are popped together.
	// the remaining beats of a write follow once the header is visible.
	assign rfif_rd = start_trans && !rfif_empty && !active_0a && !rfif_rd_1a;
	assign dfif_rd = rfif_rd || (active_0a && len_rem_0a > 'd1 && !dfif_empty);

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			rfif_rd_1a <= 1'b0;
			dfif_rd_1a <= 1'b0;
			active_0a  <= 1'b0;
			active_1a  <= 1'b0;
			len_rem_0a <= '0;
		end else begin
			rfif_rd_1a <= rfif_rd;
			dfif_rd_1a <= dfif_rd;
			active_1a  <= active_0a;
			// only writes enter the beat countdown; len already includes the first beat.
			if (rfif_rd_1a && rfif_rdat.mode == fsab_pkg::fsab_write) begin
				active_0a  <= 1'b1;
				len_rem_0a <= rfif_rdat.len;
			end else if (active_0a && dfif_rd) begin
				len_rem_0a <= len_rem_0a - 1'b1;
			end else if (active_0a && len_rem_0a <= 'd1) begin
				active_0a <= 1'b0;
			end
		end
	end

	// a write frees its data FIFO space only after the last pop.
	// a read is finished as soon as its header has been seen.
	assign credit_oclk = (active_1a && !active_0a) ||
	                     (rfif_rd_1a && rfif_rdat.mode == fsab_pkg::fsab_read);

	// active covers the header look, the countdown and the final beat.
	assign active = rfif_rd_1a || active_0a || active_1a;

	always_comb begin
		fifo_beat.valid = dfif_rd_1a;
		fifo_beat.req   = rfif_rdat;
		fifo_beat.dat   = dfif_rdat;
	end

endmodule

// File: hdl/fsab_arbiter.sv
`timescale 1ns/1ps

module fsab_arbiter (
	input  logic                            oclk,
	input  logic                            oclk_rst_b,
	input  logic [fsab_pkg::n_clients-1:0]  empty_b,
	input  logic [fsab_pkg::n_clients-1:0]  active,
	input  fsab_pkg::fsab_beat_t            fifo_beat [fsab_pkg::n_clients],
	output logic [fsab_pkg::n_clients-1:0]  start_trans,
	output fsab_pkg::fsab_beat_t            out_beat
);

	typedef enum logic {
		arb_idle,
		arb_busy
	} arb_state_e;

	arb_state_e                     state;

	// index of the current grant; it stays put in idle and so also
	// names the last grant for the round-robin search.
	logic [fsab_pkg::client_w-1:0]  grant;
	logic [fsab_pkg::client_w-1:0]  pick;
	logic                           found;

	logic                           out_valid_q;
	fsab_pkg::fsab_req_t            out_req_q;
	fsab_pkg::fsab_data_t           out_dat_q;

	// search starts at the client after the last grant and wraps around.
	always_comb begin
		int idx;
		found = 1'b0;
		pick  = grant;
		for (int off = 1; off <= fsab_pkg::n_clients; off++) begin
			idx = (int'(grant) + off) % fsab_pkg::n_clients;
			if (!found && empty_b[idx]) begin
				found = 1'b1;
				pick  = idx[fsab_pkg::client_w-1:0];
			end
		end
	end

	// one pulse per grant; busy blocks any further pulse until active falls.
	always_comb begin
		start_trans = '0;
		if (state == arb_idle && found) begin
			start_trans[pick] = 1'b1;
		end
	end

	// grant resets to the top index so that client 0 is served first.
	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			state <= arb_idle;
			grant <= '1;
		end else begin
			case (state)
				arb_idle: begin
					if (found) begin
						state <= arb_busy;
						grant <= pick;
					end
				end
				arb_busy: begin
					// the FIFO raises active the cycle after start_trans.
					if (!active[grant]) begin
						state <= arb_idle;
					end
				end
				default: state <= arb_idle;
			endcase
		end
	end

	// beats of other clients are never valid while they hold no grant.
	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			out_valid_q <= 1'b0;
		end else begin
			out_valid_q <= fifo_beat[grant].valid;
		end
	end

	always_ff @(posedge oclk) begin
		out_req_q <= fifo_beat[grant].req;
		out_dat_q <= fifo_beat[grant].dat;
	end

	always_comb begin
		out_beat.valid = out_valid_q;
		out_beat.req   = out_req_q;
		out_beat.dat   = out_dat_q;
	end

endmodule

// File: hdl/fsab_arbiter_top.sv
`timescale 1ns/1ps

module fsab_arbiter_top (
	input  logic                            iclk,
	input  logic                            iclk_rst_b,
	input  logic                            oclk,
	input  logic                            oclk_rst_b,
	input  logic [fsab_pkg::n_clients-1:0]  inp_valid,
	input  fsab_pkg::fsab_req_t             inp_req [fsab_pkg::n_clients],
	input  fsab_pkg::fsab_data_t            inp_dat [fsab_pkg::n_clients],
	output logic [fsab_pkg::n_clients-1:0]  inp_credit,
	output fsab_pkg::fsab_beat_t            out_beat
);

	// per-client control and beats, all in the oclk domain.
	logic [fsab_pkg::n_clients-1:0]  empty_b;
	logic [fsab_pkg::n_clients-1:0]  active;
	logic [fsab_pkg::n_clients-1:0]  start_trans;
	fsab_pkg::fsab_beat_t            fifo_beat [fsab_pkg::n_clients];

	// first stage: one buffer and clock crossing per client.
	for (genvar c = 0; c < fsab_pkg::n_clients; c++) begin : g_client
		fsab_arbiter_fifo u_fifo (
			.iclk        (iclk),
			.iclk_rst_b  (iclk_rst_b),
			.oclk        (oclk),
			.oclk_rst_b  (oclk_rst_b),
			.inp_valid   (inp_valid[c]),
			.inp_req     (inp_req[c]),
			.inp_dat     (inp_dat[c]),
			.inp_credit  (inp_credit[c]),
			.start_trans (start_trans[c]),
			.empty_b     (empty_b[c]),
			.active      (active[c]),
			.fifo_beat   (fifo_beat[c])
		);
	end

	// second stage: round-robin grant and the registered output bus.
	fsab_arbiter u_arbiter (
		.oclk        (oclk),
		.oclk_rst_b  (oclk_rst_b),
		.empty_b     (empty_b),
		.active      (active),
		.fifo_beat   (fifo_beat),
		.start_trans (start_trans),
		.out_beat    (out_beat)
	);

endmodule

// File: test/fsab_arbiter_checker.sv
`timescale 1ns/1ps

module fsab_arbiter_checker #(
	parameter int n_ports   = 1,
	parameter bit fifo_side = 1'b1
) (
	input logic               iclk,
	input logic               iclk_rst_b,
	input logic               oclk,
	input logic               oclk_rst_b,
	input logic [1:0]         wr_en,
	input logic [1:0]         full,
	input logic               hdr_rd,
	input logic               dat_empty,
	input logic [n_ports-1:0] start_trans,
	input logic [n_ports-1:0] active
);

	// number of failed assertions in this instance.
	int unsigned fails = 0;

	// a FIFO is never started again while it is still active.
	a_start_rules: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		(start_trans & active) == '0)
		else begin
			$error("start_trans to an active FIFO");
			fails++;
		end

	if (fifo_side) begin : g_fifo_rules
		// the credit scheme keeps clients from ever pushing into a full FIFO.
		a_no_overflow: assert property (@(posedge iclk) disable iff (!iclk_rst_b)
			(wr_en & full) == 2'b00)
			else begin
				$error("FIFO written while full");
				fails++;
			end

		// a header pop always finds its first data beat already across.
		a_no_underflow: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
			!(hdr_rd && dat_empty))
			else begin
				$error("header popped while the data FIFO was empty");
				fails++;
			end
	end else begin : g_grant_rules
		// the grant is held until active falls, so two FIFOs are never active together.
		a_one_active: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
			$onehot0(active))
			else begin
				$error("more than one FIFO active at once");
				fails++;
			end
	end

endmodule

// index 1 is the request FIFO, index 0 the data FIFO.
bind fsab_arbiter_fifo fsab_arbiter_checker #(
	.n_ports   (1),
	.fifo_side (1'b1)
) u_checker (
	.iclk        (iclk),
	.iclk_rst_b  (iclk_rst_b),
	.oclk        (oclk),
	.oclk_rst_b  (oclk_rst_b),
	.wr_en       ({rfif_wr, dfif_wr}),
	.full        ({rfif_full, dfif_full}),
	.hdr_rd      (rfif_rd),
	.dat_empty   (dfif_empty),
	.start_trans (start_trans),
	.active      (active)
);

// the arbiter holds no FIFO, so only the grant rules are checked there.
bind fsab_arbiter fsab_arbiter_checker #(
	.n_ports   (fsab_pkg::n_clients),
	.fifo_side (1'b0)
) u_checker (
	.iclk        (oclk),
	.iclk_rst_b  (oclk_rst_b),
	.oclk        (oclk),
	.oclk_rst_b  (oclk_rst_b),
	.wr_en       (2'b00),
	.full        (2'b00),
	.hdr_rd      (1'b0),
	.dat_empty   (1'b0),
	.start_trans (start_trans),
	.active      (active)
);

// File: test/fsab_arbiter_tb.sv
`timescale 1ns/1ps

module fsab_arbiter_tb;

	localparam int n_req           = 30;
	localparam int credit_wait_max = 600;
	localparam int drain_wait_max  = 3000;

	logic                            iclk;
	logic                            oclk;
	logic                            iclk_rst_b;
	logic                            oclk_rst_b;
	logic [fsab_pkg::n_clients-1:0]  inp_valid;
	fsab_pkg::fsab_req_t             inp_req [fsab_pkg::n_clients];
	fsab_pkg::fsab_data_t            inp_dat [fsab_pkg::n_clients];
	logic [fsab_pkg::n_clients-1:0]  inp_credit;
	fsab_pkg::fsab_beat_t            out_beat;

	// expected beats of all clients in send order; each client's beats keep their order.
	fsab_pkg::fsab_beat_t            exp_q [$];
	int                              credits [fsab_pkg::n_clients];
	int                              sent [fsab_pkg::n_clients];
	int                              returned [fsab_pkg::n_clients];
	fsab_pkg::fsab_mode_e            slot_mode [fsab_pkg::initial_credits];
	int                              slot_len [fsab_pkg::initial_credits];

	// packet tracking on the output bus.
	int                              burst_left;
	logic [fsab_pkg::did_w-1:0]      burst_did;
	logic [fsab_pkg::did_w-1:0]      prev_did;
	bit                              have_prev;
	bit                              check_alt;
	bit                              timed_out;

	int                              reset_errs;
	int                              data_errs;
	int                              order_errs;
	int                              credit_errs;
	int                              timeout_errs;

	fsab_arbiter_top uut (
		.iclk       (iclk),
		.iclk_rst_b (iclk_rst_b),
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.inp_valid  (inp_valid),
		.inp_req    (inp_req),
		.inp_dat    (inp_dat),
		.inp_credit (inp_credit),
		.out_beat   (out_beat)
	);

	always #20 oclk = ~oclk;
	always #15 iclk = ~iclk;

	// all client tasks start and end on a rising iclk edge.
	task automatic idle_cycles(input int c, input int n);
		repeat (n) begin
			@(negedge iclk);
			inp_valid[c] = 1'b0;
			@(posedge iclk);
		end
	endtask

	task automatic drive_beat(input int c, input fsab_pkg::fsab_beat_t beat);
		@(negedge iclk);
		inp_valid[c] = 1'b1;
		inp_req[c]   = beat.req;
		inp_dat[c]   = beat.dat;
		exp_q.push_back(beat);
		@(posedge iclk);
	endtask

	// sends one request and spends one credit. later beats of a write may pause.
	task automatic send_request(input int c, input fsab_pkg::fsab_mode_e mode, input int len,
	                            input int pause_max);
		fsab_pkg::fsab_req_t  hdr;
		fsab_pkg::fsab_beat_t beat;
		int                   waited;
		waited = 0;
		while (credits[c] == 0 && !timed_out) begin
			idle_cycles(c, 1);
			waited++;
			if (waited > credit_wait_max) begin
				$display("timeout: client %0d got no credit back", c);
				timeout_errs++;
				timed_out = 1'b1;
			end
		end
		if (timed_out) begin
			return;
		end
		credits[c]--;
		sent[c]++;
		hdr.mode   = mode;
		hdr.did    = c[fsab_pkg::did_w-1:0];
		hdr.subdid = $urandom_range(0, 15);
		hdr.addr   = $urandom();
		hdr.len    = len[fsab_pkg::len_w-1:0];
		for (int b = 0; b < len; b++) begin
			if (b > 0) begin
				idle_cycles(c, $urandom_range(0, pause_max));
			end
			beat.valid    = 1'b1;
			beat.req      = hdr;
			beat.dat.data = $urandom();
			beat.dat.mask = $urandom_range(0, 15);
			drive_beat(c, beat);
		end
	endtask

	task automatic run_random(input int c);
		fsab_pkg::fsab_mode_e mode;
		int                   len;
		for (int i = 0; i < n_req && !timed_out; i++) begin
			idle_cycles(c, $urandom_range(0, 3));
			mode = ($urandom_range(0, 1) == 1) ? fsab_pkg::fsab_write : fsab_pkg::fsab_read;
			len  = (mode == fsab_pkg::fsab_write) ? $urandom_range(1, fsab_pkg::len_max) : 1;
			send_request(c, mode, len, 2);
		end
		idle_cycles(c, 1);
	endtask

	// both clients send the same shapes in the same cycles, so both stay loaded.
	task automatic run_loaded(input int c);
		for (int k = 0; k < fsab_pkg::initial_credits && !timed_out; k++) begin
			send_request(c, slot_mode[k], slot_len[k], 0);
		end
		idle_cycles(c, 1);
	endtask

	function automatic bit drained();
		bit done;
		done = exp_q.size() == 0;
		for (int c = 0; c < fsab_pkg::n_clients; c++) begin
			done = done && credits[c] == fsab_pkg::initial_credits;
		end
		return done;
	endfunction

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (!drained() && !timed_out) begin
			@(posedge iclk);
			waited++;
			if (waited > drain_wait_max) begin
				$display("timeout: beats or credits still outstanding");
				timeout_errs++;
				timed_out = 1'b1;
			end
		end
	endtask

	// nothing may come out of the DUT before any request was sent.
	task automatic check_quiet(input int n);
		repeat (n) begin
			@(negedge oclk);
			assert (out_beat.valid == 1'b0) else begin
				$display("[ERROR] out_beat.valid: got %h expected %h", out_beat.valid, 1'b0);
				reset_errs++;
			end
			assert (inp_credit == '0) else begin
				$display("[ERROR] inp_credit: got %h expected %h", inp_credit, 2'b00);
				reset_errs++;
			end
		end
	endtask

	// credits are counted on the falling edge, where the pulse is stable.
	always @(negedge iclk) begin
		for (int c = 0; c < fsab_pkg::n_clients; c++) begin
			if (iclk_rst_b && inp_credit[c]) begin
				credits[c]++;
				returned[c]++;
				assert (credits[c] <= fsab_pkg::initial_credits) else begin
					$display("[ERROR] credits[%0d]: got %h expected at most %h", c, credits[c],
					         fsab_pkg::initial_credits);
					credit_errs++;
				end
			end
		end
	end

	// the output monitor matches each beat against the oldest expected beat of its client.
	always @(negedge oclk) begin
		int                   idx;
		fsab_pkg::fsab_beat_t want;
		if (oclk_rst_b && out_beat.valid) begin
			idx = -1;
			for (int i = 0; i < exp_q.size() && idx < 0; i++) begin
				if (exp_q[i].req.did == out_beat.req.did) begin
					idx = i;
				end
			end
			assert (idx >= 0) else begin
				$display("unexpected beat on out_beat for client %0d", out_beat.req.did);
				data_errs++;
			end
			if (idx >= 0) begin
				want = exp_q[idx];
				exp_q.delete(idx);
				assert (out_beat.req == want.req) else begin
					$display("[ERROR] out_beat.req: got %h expected %h", out_beat.req, want.req);
					data_errs++;
				end
				assert (out_beat.dat == want.dat) else begin
					$display("[ERROR] out_beat.dat: got %h expected %h", out_beat.dat, want.dat);
					data_errs++;
				end
			end
			// the beats of a write must not be split by another client.
			if (burst_left > 0) begin
				assert (out_beat.req.did == burst_did) else begin
					$display("[ERROR] out_beat.req.did: got %h expected %h", out_beat.req.did,
					         burst_did);
					order_errs++;
				end
				burst_left--;
			end else begin
				if (check_alt && have_prev) begin
					assert (out_beat.req.did != prev_did) else begin
						$display("client %0d was served twice in a row while both were loaded",
						         prev_did);
						order_errs++;
					end
				end
				prev_did   = out_beat.req.did;
				have_prev  = 1'b1;
				burst_did  = out_beat.req.did;
				burst_left = (out_beat.req.mode == fsab_pkg::fsab_write) ?
				             int'(out_beat.req.len) - 1 : 0;
			end
		end
	end

	initial begin
		int total;
		int assert_fails;
		void'($urandom(32'hd7ec));
		iclk         = 1'b0;
		oclk         = 1'b0;
		iclk_rst_b   = 1'b0;
		oclk_rst_b   = 1'b0;
		inp_valid    = '0;
		burst_left   = 0;
		burst_did    = '0;
		prev_did     = '0;
		have_prev    = 1'b0;
		check_alt    = 1'b0;
		timed_out    = 1'b0;
		reset_errs   = 0;
		data_errs    = 0;
		order_errs   = 0;
		credit_errs  = 0;
		timeout_errs = 0;
		for (int c = 0; c < fsab_pkg::n_clients; c++) begin
			inp_req[c]  = '0;
			inp_dat[c]  = '0;
			credits[c]  = fsab_pkg::initial_credits;
			sent[c]     = 0;
			returned[c] = 0;
		end
		repeat (2) @(posedge oclk);
		@(negedge oclk);
		iclk_rst_b = 1'b1;
		oclk_rst_b = 1'b1;
		check_quiet(12);

		fork
			run_random(0);
			run_random(1);
		join
		wait_drain();

		// one shared list of shapes for the loaded phase.
		for (int k = 0; k < fsab_pkg::initial_credits; k++) begin
			slot_mode[k] = ($urandom_range(0, 1) == 1) ? fsab_pkg::fsab_write : fsab_pkg::fsab_read;
			slot_len[k]  = (slot_mode[k] == fsab_pkg::fsab_write) ?
			               $urandom_range(1, fsab_pkg::len_max) : 1;
		end
		have_prev = 1'b0;
		check_alt = 1'b1;
		fork
			run_loaded(0);
			run_loaded(1);
		join
		wait_drain();
		// a stray beat after the drain shows up as an unexpected beat.
		repeat (20) @(posedge oclk);
		check_alt = 1'b0;

		for (int c = 0; c < fsab_pkg::n_clients; c++) begin
			assert (credits[c] == fsab_pkg::initial_credits) else begin
				$display("[ERROR] credits[%0d]: got %h expected %h", c, credits[c],
				         fsab_pkg::initial_credits);
				credit_errs++;
			end
			assert (returned[c] == sent[c]) else begin
				$display("[ERROR] returned[%0d]: got %h expected %h", c, returned[c], sent[c]);
				credit_errs++;
			end
		end
		assert (exp_q.size() == 0) else begin
			$display("%0d expected beats never appeared on out_beat", exp_q.size());
			data_errs++;
		end

		assert_fails = uut.g_client[0].u_fifo.u_checker.fails +
		               uut.g_client[1].u_fifo.u_checker.fails +
		               uut.u_arbiter.u_checker.fails;
		total = reset_errs + data_errs + order_errs + credit_errs + timeout_errs + assert_fails;
		$display("errors: reset %0d, data %0d, order %0d, credit %0d, timeout %0d, assertion %0d",
		         reset_errs, data_errs, order_errs, credit_errs, timeout_errs, assert_fails);
		if (total == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
hdl/fsab_pkg.sv
hdl/async_fifo.sv
hdl/credit_return_sync.sv
hdl/fsab_arbiter_fifo.sv
hdl/fsab_arbiter.sv
hdl/fsab_arbiter_top.sv
test/fsab_arbiter_checker.sv
test/fsab_arbiter_tb.sv

// File: Bender.yml
package:
  name: fsab_arbiter

sources:
  - hdl/fsab_pkg.sv
  - hdl/async_fifo.sv
  - hdl/credit_return_sync.sv
  - hdl/fsab_arbiter_fifo.sv
  - hdl/fsab_arbiter.sv
  - hdl/fsab_arbiter_top.sv
  - target: test
    files:
      - test/fsab_arbiter_checker.sv
      - test/fsab_arbiter_tb.sv
